// ==== logic/prefetch_pkg.sv ====
/* Shared widths, enums and packed structs of the instruction prefetch buffer.
   Imported by every RTL block and by the testbench. */
package prefetch_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  parameter int unsigned ADDR_W = 32;
  parameter int unsigned INSTR_W = 32;

  // default number of 32-bit words in one memory line
  parameter int unsigned LINE_WORDS_DEF = 4;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [INSTR_W-1:0] instr_t;

  //////////////////////////////////////////////////
  // enums
  //////////////////////////////////////////////////

  // controller states
  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID,
    VALID,
    CROSS_WAIT_GNT,
    CROSS_WAIT_RVALID,
    FLUSH
  } fetch_state_e;

  // line buffer commands
  typedef enum logic [1:0] {
    BUF_HOLD,
    BUF_LOAD,
    BUF_SAVE_UPPER
  } buf_op_e;

  //////////////////////////////////////////////////
  // structs
  //////////////////////////////////////////////////

  // request toward instruction memory, addr is line aligned
  typedef struct packed {
    logic  req;
    addr_t addr;
  } mem_req_t;

  // memory handshake, line data has its own port
  typedef struct packed {
    logic gnt;
    logic rvalid;
  } mem_rsp_t;

  // instruction handed to decode
  typedef struct packed {
    logic   valid;
    instr_t rdata;
    addr_t  addr;
  } instr_out_t;

endpackage

// ==== logic/prefetch_ctrl.sv ====
/* FSM of the prefetch buffer: sequences line fetches, crossword assembly and
   branch flushes, and drives the line buffer and address counter commands. */
module prefetch_ctrl
  import prefetch_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     branch_i,
  input  logic     ready_i,
  input  mem_rsp_t mem_rsp_i,
  input  logic     is_compressed_i,
  input  logic     is_crossword_i,
  input  logic     at_line_end_i,
  output logic     req_o,
  output logic     fetch_next_line_o,
  output buf_op_e  buf_op_o,
  output logic     addr_load_o,
  output logic     addr_advance_o,
  output logic     valid_o,
  output logic     busy_o
);

  fetch_state_e state_q, state_d;

  // set from the upper-half save until the assembled crossword is accepted
  logic cross_q, cross_d;

  logic need_cross;
  logic rsp_owed;

  // only a full instruction in the last halfword needs the next line first
  assign need_cross = is_crossword_i & ~is_compressed_i;

  // a response is still on its way after this cycle
  always_comb begin
    rsp_owed = 1'b0;
    case (state_q)
      WAIT_GNT, CROSS_WAIT_GNT:       rsp_owed = mem_rsp_i.gnt;
      WAIT_RVALID, CROSS_WAIT_RVALID: rsp_owed = ~mem_rsp_i.rvalid;
      FLUSH:                          rsp_owed = ~mem_rsp_i.rvalid;
      default:                        rsp_owed = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // next state and commands
  //////////////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    cross_d        = cross_q;
    req_o          = 1'b0;
    buf_op_o       = BUF_HOLD;
    addr_load_o    = 1'b0;
    addr_advance_o = 1'b0;
    valid_o        = 1'b0;

    case (state_q)
      IDLE: begin
        // nothing to do until the first branch
      end

      WAIT_GNT: begin
        req_o = 1'b1;
        if (mem_rsp_i.gnt) begin
          state_d = WAIT_RVALID;
        end
      end

      WAIT_RVALID: begin
        if (mem_rsp_i.rvalid) begin
          buf_op_o = BUF_LOAD;
          state_d  = VALID;
        end
      end

      VALID: begin
        if (need_cross) begin
          // keep the lower half, then bring in the line holding the upper half
          buf_op_o = BUF_SAVE_UPPER;
          cross_d  = 1'b1;
          state_d  = CROSS_WAIT_GNT;
        end else begin
          valid_o = ~branch_i;
          if (ready_i) begin
            addr_advance_o = 1'b1;
            cross_d        = 1'b0;
            // next instruction starts in the following line
            if (at_line_end_i) begin
              state_d = WAIT_GNT;
            end
          end
        end
      end

      CROSS_WAIT_GNT: begin
        req_o = 1'b1;
        if (mem_rsp_i.gnt) begin
          state_d = CROSS_WAIT_RVALID;
        end
      end

      CROSS_WAIT_RVALID: begin
        if (mem_rsp_i.rvalid) begin
          buf_op_o = BUF_LOAD;
          state_d  = VALID;
        end
      end

      FLUSH: begin
        // stale line is dropped, fetch for the target goes out next cycle
        if (mem_rsp_i.rvalid) begin
          state_d = WAIT_GNT;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase

    // branch wins over everything above
    if (branch_i) begin
      addr_load_o    = 1'b1;
      addr_advance_o = 1'b0;
      buf_op_o       = BUF_HOLD;
      cross_d        = 1'b0;
      state_d        = rsp_owed ? FLUSH : WAIT_GNT;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      cross_q <= 1'b0;
    end else begin
      state_q <= state_d;
      cross_q <= cross_d;
    end
  end

  // during crossword handling the fetch targets the line after addr
  assign fetch_next_line_o = cross_q;

  assign busy_o = (state_q != IDLE) && (state_q != VALID);

endmodule

// ==== logic/fetch_addr_counter.sv ====
/* Holds the current halfword instruction address and forms the line-aligned
   fetch address; loaded on branches, advanced by 2 or 4 on accepted instructions. */
module fetch_addr_counter
  import prefetch_pkg::*;
#(
  parameter int unsigned LINE_WORDS = LINE_WORDS_DEF
) (
  input  logic  clk,
  input  logic  rst_n,
  input  addr_t branch_addr_i,
  input  logic  load_i,
  input  logic  advance_i,
  input  logic  is_compressed_i,
  input  logic  fetch_next_line_i,
  output addr_t addr_o,
  output addr_t fetch_addr_o
);

  // byte offset bits inside one line
  localparam int unsigned OFF_W = $clog2(LINE_WORDS * 4);
  localparam addr_t LINE_BYTES = addr_t'(LINE_WORDS * 4);

  addr_t addr_q;
  addr_t step;
  addr_t line_base;

  assign step = is_compressed_i ? addr_t'(2) : addr_t'(4);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (load_i) begin
      // targets are halfword aligned, bit 0 is ignored
      addr_q <= {branch_addr_i[ADDR_W-1:1], 1'b0};
    end else if (advance_i) begin
      addr_q <= addr_q + step;
    end
  end

  assign line_base = {addr_q[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};

  assign fetch_addr_o = fetch_next_line_i ? line_base + LINE_BYTES : line_base;

  assign addr_o = addr_q;

endmodule

// ==== logic/line_buffer.sv ====
/* Storage for the last line returned by memory and the saved upper halfword
   of the previous line, used to assemble crossword instructions. */
module line_buffer
  import prefetch_pkg::*;
#(
  parameter int unsigned LINE_WORDS = LINE_WORDS_DEF
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  buf_op_e                      buf_op_i,
  input  logic [LINE_WORDS-1:0][31:0]  rdata_line_i,
  output logic [LINE_WORDS-1:0][31:0]  line_o,
  output logic [15:0]                  saved_half_o
);

  logic [LINE_WORDS-1:0][31:0] line_q;
  logic [15:0]                 saved_q;

  //////////////////////////////////////////////////
  // line register
  //////////////////////////////////////////////////

  // written on the edge that closes the rvalid cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      line_q <= '0;
    end else if (buf_op_i == BUF_LOAD) begin
      line_q <= rdata_line_i;
    end
  end

  //////////////////////////////////////////////////
  // saved halfword
  //////////////////////////////////////////////////

  // last halfword of the current line, i.e. the low half of a crossword
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      saved_q <= '0;
    end else if (buf_op_i == BUF_SAVE_UPPER) begin
      saved_q <= line_q[LINE_WORDS-1][31:16];
    end
  end

  assign line_o       = line_q;
  assign saved_half_o = saved_q;

endmodule

// ==== logic/instr_aligner.sv ====
/* Combinational extraction of the instruction at the current halfword address,
   with compressed, crossword and line-end flags for the controller. */
module instr_aligner
  import prefetch_pkg::*;
#(
  parameter int unsigned LINE_WORDS = LINE_WORDS_DEF
) (
  input  addr_t                       addr_i,
  input  logic [LINE_WORDS-1:0][31:0] line_i,
  input  logic [15:0]                 saved_half_i,
  input  logic                        use_saved_i,
  output instr_t                      instr_o,
  output logic                        is_compressed_o,
  output logic                        is_crossword_o,
  output logic                        at_line_end_o
);

  localparam int unsigned HALVES = 2 * LINE_WORDS;
  localparam int unsigned IDX_W = $clog2(HALVES);
  localparam logic [IDX_W-1:0] LAST_HALF = IDX_W'(HALVES - 1);
  localparam logic [IDX_W-1:0] PREV_HALF = IDX_W'(HALVES - 2);

  logic [HALVES-1:0][15:0] halves;
  logic [IDX_W-1:0]        idx;
  logic [IDX_W-1:0]        idx_next;
  logic [15:0]             lo_half;
  logic                    compressed;
  logic                    at_last;

  // same bits viewed as halfwords, halves[0] is the lowest address
  assign halves = line_i;

  // halfword index within the line
  assign idx = addr_i[IDX_W:1];

  // wraps to halfword 0 at the line end, which after a crossword fetch
  // already holds the first halfword of the next line
  assign idx_next = idx + IDX_W'(1);

  //////////////////////////////////////////////////
  // extraction
  //////////////////////////////////////////////////

  assign lo_half = use_saved_i ? saved_half_i : halves[idx];

  assign instr_o = {halves[idx_next], lo_half};

  assign compressed = (lo_half[1:0] != 2'b11);

  //////////////////////////////////////////////////
  // flags
  //////////////////////////////////////////////////

  assign at_last = ~use_saved_i & (idx == LAST_HALF);

  // the 32-bit window here reaches into the next line
  assign is_crossword_o = at_last;

  // this instruction occupies the last halfword, next one is in the next line
  assign at_line_end_o = ~use_saved_i &
                         ((at_last & compressed) | ((idx == PREV_HALF) & ~compressed));

  assign is_compressed_o = compressed;

endmodule

// ==== logic/prefetch_top.sv ====
/* Top level of the instruction prefetch buffer. Connects the controller, address
   counter, line buffer and aligner to the processor and memory ports. */
module prefetch_top
  import prefetch_pkg::*;
#(
  parameter int unsigned LINE_WORDS = LINE_WORDS_DEF
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        branch_i,
  input  addr_t                       branch_addr_i,
  input  logic                        ready_i,
  output instr_out_t                  instr_o,
  output mem_req_t                    mem_req_o,
  input  mem_rsp_t                    mem_rsp_i,
  input  logic [LINE_WORDS-1:0][31:0] mem_rdata_i,
  output logic                        busy_o
);

  logic                        req;
  logic                        fetch_next_line;
  buf_op_e                     buf_op;
  logic                        addr_load;
  logic                        addr_advance;
  logic                        valid;
  logic                        is_compressed;
  logic                        is_crossword;
  logic                        at_line_end;
  addr_t                       addr;
  addr_t                       fetch_addr;
  logic [LINE_WORDS-1:0][31:0] line;
  logic [15:0]                 saved_half;
  instr_t                      instr;

  prefetch_ctrl ctrl_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .branch_i          (branch_i),
    .ready_i           (ready_i),
    .mem_rsp_i         (mem_rsp_i),
    .is_compressed_i   (is_compressed),
    .is_crossword_i    (is_crossword),
    .at_line_end_i     (at_line_end),
    .req_o             (req),
    .fetch_next_line_o (fetch_next_line),
    .buf_op_o          (buf_op),
    .addr_load_o       (addr_load),
    .addr_advance_o    (addr_advance),
    .valid_o           (valid),
    .busy_o            (busy_o)
  );

  fetch_addr_counter #(.LINE_WORDS(LINE_WORDS)) counter_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .branch_addr_i     (branch_addr_i),
    .load_i            (addr_load),
    .advance_i         (addr_advance),
    .is_compressed_i   (is_compressed),
    .fetch_next_line_i (fetch_next_line),
    .addr_o            (addr),
    .fetch_addr_o      (fetch_addr)
  );

  line_buffer #(.LINE_WORDS(LINE_WORDS)) buffer_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .buf_op_i     (buf_op),
    .rdata_line_i (mem_rdata_i),
    .line_o       (line),
    .saved_half_o (saved_half)
  );

  // the low half comes from the saved register while a crossword is in hand
  instr_aligner #(.LINE_WORDS(LINE_WORDS)) aligner_i (
    .addr_i          (addr),
    .line_i          (line),
    .saved_half_i    (saved_half),
    .use_saved_i     (fetch_next_line),
    .instr_o         (instr),
    .is_compressed_o (is_compressed),
    .is_crossword_o  (is_crossword),
    .at_line_end_o   (at_line_end)
  );

  assign mem_req_o.req  = req;
  assign mem_req_o.addr = fetch_addr;

  assign instr_o.valid = valid;
  assign instr_o.rdata = instr;
  assign instr_o.addr  = addr;

endmodule

// ==== verification/tb_clock_gen.sv ====
/* Clock and reset source of the prefetch testbench: free running clock,
   active low reset held for a few cycles after time zero. */
module tb_clock_gen #(
  parameter int unsigned PERIOD_NS    = 8,
  parameter int unsigned RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release on a rising edge so the first active cycle is a full one
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// ==== verification/tb_mem_model.sv ====
/* Line-organized instruction memory for the prefetch testbench with random grant
   and response delays. Serves one request at a time. */
module tb_mem_model
  import prefetch_pkg::*;
#(
  parameter int unsigned LINE_WORDS = LINE_WORDS_DEF
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  mem_req_t                    req_i,
  output mem_rsp_t                    rsp_o,
  output logic [LINE_WORDS-1:0][31:0] rdata_o,
  output logic                        pending_o
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int DEPTH = 256;

  // halfword image, index is byte address bits [8:1]
  logic [15:0] image [DEPTH];

  logic [31:0]                 seed_q;
  logic [31:0]                 seed_next;
  logic [2:0]                  waited_q;
  logic [2:0]                  gnt_delay_q;
  logic [1:0]                  rsp_delay;
  logic [1:0]                  rsp_cnt_q;
  logic                        pend_q;
  logic                        rvalid_q;
  logic                        gnt;
  logic [LINE_WORDS-1:0][31:0] line_q;

  //////////////////////////////////////////////////
  // image
  //////////////////////////////////////////////////

  // 0x000-0x03f only full encodings, 0x040 compressed then full up to 0x07f,
  // mixed above
  function automatic logic [15:0] fill_half(input logic [7:0] h);
    logic [15:0] v;
    v = {h, ~h} ^ 16'h5a3c ^ {h[3:0], h, h[7:4]};
    if (h < 8'd32) begin
      v[1:0] = 2'b11;
    end else if (h == 8'd32) begin
      v[1:0] = 2'b01;
    end else if ((h < 8'd64) || v[4]) begin
      v[1:0] = 2'b11;
    end
    return v;
  endfunction

  function automatic logic [LINE_WORDS-1:0][31:0] read_line(input addr_t a);
    logic [LINE_WORDS-1:0][31:0] l;
    logic [7:0]                  base;
    base = a[8:1] & ~8'(2 * LINE_WORDS - 1);
    for (int w = 0; w < LINE_WORDS; w++) begin
      l[w] = {image[base + 8'(2 * w + 1)], image[base + 8'(2 * w)]};
    end
    return l;
  endfunction

  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      image[i] = fill_half(8'(i));
    end
  end

  //////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  assign seed_next = lcg_next(seed_q);
  // 1 to 3 cycles from grant to rvalid
  assign rsp_delay = (seed_next[25:24] == 2'd0) ? 2'd3 : seed_next[25:24];

  assign gnt = req_i.req && !pend_q && !rvalid_q && (waited_q >= gnt_delay_q);

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seed_q      <= 32'd90;
      waited_q    <= '0;
      gnt_delay_q <= '0;
      rsp_cnt_q   <= '0;
      pend_q      <= 1'b0;
      rvalid_q    <= 1'b0;
      line_q      <= '0;
    end else begin
      rvalid_q <= 1'b0;
      if (gnt) begin
        seed_q      <= seed_next;
        waited_q    <= '0;
        gnt_delay_q <= {1'b0, seed_next[29:28]};
        line_q      <= read_line(req_i.addr);
        if (rsp_delay == 2'd1) begin
          rvalid_q <= 1'b1;
        end else begin
          pend_q    <= 1'b1;
          rsp_cnt_q <= rsp_delay - 2'd1;
        end
      end else if (req_i.req) begin
        waited_q <= waited_q + 3'd1;
      end
      if (pend_q) begin
        if (rsp_cnt_q == 2'd1) begin
          rvalid_q <= 1'b1;
          pend_q   <= 1'b0;
        end else begin
          rsp_cnt_q <= rsp_cnt_q - 2'd1;
        end
      end
    end
  end

  assign rsp_o.gnt    = gnt;
  assign rsp_o.rvalid = rvalid_q;
  assign rdata_o      = line_q;
  assign pending_o    = pend_q | rvalid_q;

endmodule

// ==== verification/tb_prefetch.sv ====
/* Testbench top of the prefetch buffer. Applies the stimulus table, follows the
   expected instruction stream through the memory image and checks each accepted instruction. */
module tb_prefetch
  import prefetch_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned LINE_WORDS = LINE_WORDS_DEF;
  localparam addr_t LINE_MASK = addr_t'(LINE_WORDS * 4 - 1);
  localparam int NUM_TESTS = 12;
  localparam int CYCLES_PER_TEST = 200;

  typedef struct packed {
    addr_t      target;
    int         count;
    logic [7:0] ready_pat;
    int         mid_cyc;
    addr_t      mid_target;
  } test_t;

  logic                        clk;
  logic                        rst_n;
  logic                        branch;
  addr_t                       branch_addr;
  logic                        ready;
  instr_out_t                  instr;
  mem_req_t                    mem_req;
  mem_rsp_t                    mem_rsp;
  logic [LINE_WORDS-1:0][31:0] mem_rdata;
  logic                        busy;
  logic                        mem_pending;

  int errors;
  int checks;
  int failed_tests;

  // target, instructions accepted after the last branch, ready bit per cycle,
  // cycle of a second branch (0 for none) and its target
  test_t tests [NUM_TESTS] = '{
    '{32'h0000_0000, 10, 8'hff, 0, 32'h0000_0000},
    '{32'h0000_0040, 12, 8'hff, 0, 32'h0000_0000},
    '{32'h0000_0082, 16, 8'hff, 0, 32'h0000_0000},
    '{32'h0000_0100, 8, 8'hff, 1, 32'h0000_0046},
    '{32'h0000_0120, 8, 8'hff, 2, 32'h0000_0010},
    '{32'h0000_0048, 10, 8'b0110_1101, 0, 32'h0000_0000},
    '{32'h0000_019a, 12, 8'b1001_0011, 0, 32'h0000_0000},
    '{32'h0000_0150, 10, 8'hff, 9, 32'h0000_004c},
    '{32'h0000_01e6, 14, 8'b1110_1011, 0, 32'h0000_0000},
    '{32'h0000_00c4, 16, 8'b0111_1110, 6, 32'h0000_016e},
    '{32'h0000_003e, 12, 8'hff, 0, 32'h0000_0000},
    '{32'h0000_00f2, 16, 8'b1101_1010, 3, 32'h0000_0132}
  };

  tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(2)) clock_i (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  tb_mem_model #(.LINE_WORDS(LINE_WORDS)) mem_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_i     (mem_req),
    .rsp_o     (mem_rsp),
    .rdata_o   (mem_rdata),
    .pending_o (mem_pending)
  );

  prefetch_top #(.LINE_WORDS(LINE_WORDS)) dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch),
    .branch_addr_i (branch_addr),
    .ready_i       (ready),
    .instr_o       (instr),
    .mem_req_o     (mem_req),
    .mem_rsp_i     (mem_rsp),
    .mem_rdata_i   (mem_rdata),
    .busy_o        (busy)
  );

  //////////////////////////////////////////////////
  // checks and reference stream
  //////////////////////////////////////////////////

  function automatic logic [15:0] image_half(input addr_t a);
    return mem_i.image[a[8:1]];
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    assert (got == exp) else begin
      $display("CHECK FAILED: %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
      $display("CHECK FAILED: %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // a request must bring in a line holding a halfword of the next expected instruction
  task automatic check_fetch_line(input addr_t exp_addr);
    addr_t       lo_line;
    addr_t       hi_line;
    logic [15:0] lo;
    lo      = image_half(exp_addr);
    lo_line = exp_addr & ~LINE_MASK;
    hi_line = lo_line;
    if (lo[1:0] == 2'b11) begin
      hi_line = (exp_addr + 32'd2) & ~LINE_MASK;
    end
    checks++;
    assert ((mem_req.addr == lo_line) || (mem_req.addr == hi_line)) else begin
      $display("CHECK FAILED: mem_req_o.addr got %h expected %h or %h",
               mem_req.addr, lo_line, hi_line);
      errors++;
    end
  endtask

  // full encodings step by 4, compressed ones by 2 and only their low half counts
  task automatic check_accept(inout addr_t exp_addr);
    logic [15:0] lo;
    logic [15:0] hi;
    lo = image_half(exp_addr);
    hi = image_half(exp_addr + 32'd2);
    check_word("instr_o.addr", instr.addr, exp_addr);
    if (lo[1:0] == 2'b11) begin
      check_word("instr_o.rdata", instr.rdata, {hi, lo});
      exp_addr = exp_addr + 32'd4;
    end else begin
      check_word("instr_o.rdata[15:0]", {16'h0, instr.rdata[15:0]}, {16'h0, lo});
      exp_addr = exp_addr + 32'd2;
    end
  endtask

  task automatic run_test(input int idx);
    test_t      t;
    addr_t      exp_addr;
    int         got;
    int         cyc;
    int         errs_before;
    logic       held;
    instr_out_t held_instr;
    t           = tests[idx];
    errs_before = errors;
    @(posedge clk);
    branch      <= 1'b1;
    branch_addr <= t.target;
    ready       <= t.ready_pat[0];
    exp_addr    = {t.target[ADDR_W-1:1], 1'b0};
    got         = 0;
    cyc         = 0;
    held        = 1'b0;
    while (got < t.count) begin
      @(negedge clk);
      check_bit("busy_o", busy, mem_req.req | mem_pending);
      if (branch) begin
        check_bit("instr_o.valid", instr.valid, 1'b0);
        // second branch restarts the expected stream
        if (cyc != 0) begin
          exp_addr = {t.mid_target[ADDR_W-1:1], 1'b0};
          got      = 0;
        end
        held = 1'b0;
      end else begin
        if (mem_req.req) begin
          check_fetch_line(exp_addr);
        end
        if (held) begin
          check_bit("instr_o.valid", instr.valid, held_instr.valid);
          check_word("instr_o.rdata", instr.rdata, held_instr.rdata);
          check_word("instr_o.addr", instr.addr, held_instr.addr);
        end
        if (instr.valid && ready) begin
          check_accept(exp_addr);
          got++;
        end
        held       = instr.valid && !ready;
        held_instr = instr;
      end
      @(posedge clk);
      cyc++;
      if ((t.mid_cyc != 0) && (cyc == t.mid_cyc)) begin
        branch      <= 1'b1;
        branch_addr <= t.mid_target;
      end else begin
        branch <= 1'b0;
      end
      ready <= t.ready_pat[3'(cyc)];
    end
    if (errors != errs_before) begin
      failed_tests++;
    end
    $display("test %0d: target %h, %0d instructions accepted, %0d errors",
             idx, t.target, got, errors - errs_before);
  endtask

  //////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    branch       = 1'b0;
    branch_addr  = '0;
    ready        = 1'b0;
    errors       = 0;
    checks       = 0;
    failed_tests = 0;
    @(posedge rst_n);
    @(negedge clk);
    check_bit("mem_req_o.req", mem_req.req, 1'b0);
    check_bit("instr_o.valid", instr.valid, 1'b0);
    check_bit("busy_o", busy, 1'b0);
    for (int i = 0; i < NUM_TESTS; i++) begin
      run_test(i);
    end
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             NUM_TESTS, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles",
             NUM_TESTS * CYCLES_PER_TEST);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== prefetch_l0.f ====
logic/prefetch_pkg.sv
logic/prefetch_ctrl.sv
logic/fetch_addr_counter.sv
logic/line_buffer.sv
logic/instr_aligner.sv
logic/prefetch_top.sv
verification/tb_clock_gen.sv
verification/tb_mem_model.sv
verification/tb_prefetch.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the prefetch buffer testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_prefetch -f prefetch_l0.f \
  && ./obj_dir/Vtb_prefetch | tee /dev/stderr | grep -qx "TEST RESULT: PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
